//--- verilog/video_config.svh
// video config with frame geometry, sync placement and palette size
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// whole frame in pixel strobes and lines
`define VID_H_TOTAL       64
`define VID_V_TOTAL       24

// active window
// width must stay a multiple of 16 so every mode ends on a word
`define VID_H_ACTIVE      32
`define VID_V_ACTIVE      16

// sync pulses inside the blanking interval
`define VID_H_SYNC_START  40
`define VID_H_SYNC_LEN    8
`define VID_V_SYNC_LINE   20

// screen memory word address
`define VID_ADDR_W        10

`define VID_PAL_SIZE      256

`endif

//--- verilog/video_pkg.sv
// video package holding the render mode encoding and shared packed structs
package video_pkg;

	typedef enum logic [1:0] {
		RENDER_ZX   = 2'd0,
		RENDER_HC   = 2'd1,
		RENDER_XC   = 2'd2,
		RENDER_TEST = 2'd3
	} render_mode_e;

	typedef struct packed {
		render_mode_e render;
		logic         hires;
	} video_mode_t;

	// first three are single clock strobes
	typedef struct packed {
		logic pix_stb;
		logic pix_start;
		logic line_start;
		logic hvpix;
		logic hsync;
		logic vsync;
	} beam_ctrl_t;

	typedef struct packed {
		logic       stb;
		logic [7:0] index;
		logic       hsync;
		logic       vsync;
		logic       blank;
	} pix_idx_t;

	typedef struct packed {
		logic        we;
		logic [7:0]  addr;
		logic [15:0] rgb;
	} pal_wr_t;

	// rgb565 pixel leaving the subsystem
	typedef struct packed {
		logic        stb;
		logic [15:0] rgb;
		logic        hsync;
		logic        vsync;
		logic        blank;
	} video_out_t;

endpackage

//--- verilog/video_timing.sv
// video timing control with pixel-rate divider, beam counters and sync decode
`timescale 1ns/1ps
`include "video_config.svh"

module video_timing
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  video_mode_t mode,
	output beam_ctrl_t  beam,
	output logic        frame_start
);

	localparam int HW = $clog2(`VID_H_TOTAL);
	localparam int VW = $clog2(`VID_V_TOTAL);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic          div;
	logic          hires;
	logic          h_end;
	logic          v_end;
	logic          v_act;
	logic          row_start;

	assign h_end     = hcnt == HW'(`VID_H_TOTAL - 1);
	assign v_end     = vcnt == VW'(`VID_V_TOTAL - 1);
	assign v_act     = vcnt < VW'(`VID_V_ACTIVE);
	assign row_start = beam.pix_stb & (hcnt == '0);

	// hires strobes every clock, lores every second clock
	assign beam.pix_stb = hires | div;

	// active lines begin at horizontal position 0
	assign beam.line_start = row_start & v_act;
	assign beam.pix_start  = row_start & v_act;
	assign beam.hvpix      = v_act & (hcnt < HW'(`VID_H_ACTIVE));

	assign beam.hsync = (hcnt >= HW'(`VID_H_SYNC_START)) &
		(hcnt < HW'(`VID_H_SYNC_START + `VID_H_SYNC_LEN));
	assign beam.vsync = vcnt == VW'(`VID_V_SYNC_LINE);

	// last line of vertical blanking
	// leaves the fetcher time to prime the first word
	assign frame_start = row_start & v_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div   <= 1'b0;
			hires <= 1'b0;
			hcnt  <= '0;
			vcnt  <= '0;
		end else begin
			div <= ~div;
			// rate only changes between lines
			if (beam.line_start)
				hires <= mode.hires;
			if (beam.pix_stb) begin
				hcnt <= h_end ? '0 : hcnt + 1'b1;
				if (h_end)
					vcnt <= v_end ? '0 : vcnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/video_fetch.sv
// video fetcher with screen-memory address counter and one-word prefetch buffer
`timescale 1ns/1ps
`include "video_config.svh"

module video_fetch
	import video_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  beam_ctrl_t             beam,
	input  logic                   frame_start,
	input  logic [`VID_ADDR_W-1:0] frame_base,
	input  logic                   take,
	output logic [31:0]            word,
	output logic                   mem_rd,
	output logic [`VID_ADDR_W-1:0] mem_addr,
	input  logic [31:0]            mem_rdata
);

	logic [`VID_ADDR_W-1:0] next_addr;
	logic                   prime;
	logic                   fill;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			next_addr <= '0;
			prime     <= 1'b0;
			fill      <= 1'b0;
			mem_rd    <= 1'b0;
		end else begin
			fill   <= mem_rd;
			mem_rd <= 1'b0;
			if (frame_start) begin
				next_addr <= frame_base;
				prime     <= 1'b1;
			end else if ((prime & beam.pix_stb & ~beam.hvpix) | take) begin
				// priming read in blanking or refill after a take
				mem_rd    <= 1'b1;
				mem_addr  <= next_addr;
				next_addr <= next_addr + 1'b1;
				prime     <= 1'b0;
			end
		end
	end

	// memory answers one clock after the strobe
	always_ff @(posedge clk) begin
		if (fill)
			word <= mem_rdata;
	end

endmodule

//--- verilog/video_render.sv
// video renderer decoding screen words into palette indices in ZX, 16c and 256c modes
`timescale 1ns/1ps

module video_render
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  beam_ctrl_t  beam,
	input  video_mode_t mode,
	input  logic [7:0]  border,
	input  logic [31:0] word,
	output logic        take,
	output pix_idx_t    pix
);

	render_mode_e mode_q;
	render_mode_e cur_mode;
	logic [3:0]   cnt;
	logic [3:0]   cnt_nx;
	logic [31:0]  data;
	logic [31:0]  data_nx;
	logic         last;
	logic [15:0]  zx_gfx;
	logic [7:0]   zx_attr;
	logic         zx_dot;
	logic [7:0]   zx_pix;
	logic [7:0]   hc_pix;
	logic [7:0]   xc_pix;
	logic [7:0]   idx;

	// new mode already applies to the first pixel of the line
	assign cur_mode = beam.line_start ? mode.render : mode_q;

	// a word is taken at line start and on the first pixel of each later word
	// nothing is taken past the right edge of the window
	assign take = beam.pix_stb & (beam.pix_start | (beam.hvpix & last));

	// state as it stands after this strobe
	assign cnt_nx  = beam.pix_start ? 4'd0 : cnt + 4'd1;
	assign data_nx = take ? word : data;

	// zx bitmap with attribute per half word
	assign zx_gfx  = data_nx[15:0];
	assign zx_dot  = zx_gfx[~cnt_nx];
	assign zx_attr = cnt_nx[3] ? data_nx[23:16] : data_nx[31:24];
	assign zx_pix  = {4'hF, zx_attr[6], zx_dot ? zx_attr[2:0] : zx_attr[5:3]};

	// high nibble of each byte comes first
	assign hc_pix = {4'hE, data_nx[{cnt_nx[2:1], ~cnt_nx[0], 2'b00} +: 4]};
	assign xc_pix = data_nx[{cnt_nx[1:0], 3'b000} +: 8];

	always_comb begin
		case (cur_mode)
			RENDER_HC: last = cnt[2:0] == 3'd7;
			RENDER_XC: last = cnt[1:0] == 2'd3;
			default:   last = cnt == 4'd15;
		endcase
		case (cur_mode)
			RENDER_ZX: idx = zx_pix;
			RENDER_HC: idx = hc_pix;
			RENDER_XC: idx = xc_pix;
			default:   idx = 8'h00;
		endcase
		if (!beam.hvpix)
			idx = border;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode_q    <= RENDER_ZX;
			cnt       <= 4'd0;
			pix.stb   <= 1'b0;
			pix.hsync <= 1'b0;
			pix.vsync <= 1'b0;
			pix.blank <= 1'b1;
		end else begin
			pix.stb <= beam.pix_stb;
			if (beam.line_start)
				mode_q <= mode.render;
			if (beam.pix_stb) begin
				cnt       <= cnt_nx;
				pix.index <= idx;
				pix.hsync <= beam.hsync;
				pix.vsync <= beam.vsync;
				pix.blank <= ~beam.hvpix;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beam.pix_stb)
			data <= data_nx;
	end

endmodule

//--- verilog/video_palette.sv
// video palette RAM mapping 8-bit indices to RGB565 with sync carried alongside
`timescale 1ns/1ps
`include "video_config.svh"

module video_palette
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  pal_wr_t    wr,
	input  pix_idx_t   pix,
	output video_out_t out
);

	logic [15:0] ram [`VID_PAL_SIZE];

	// read returns the old entry on a same-cycle write
	always_ff @(posedge clk) begin
		if (wr.we)
			ram[wr.addr] <= wr.rgb;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out.stb   <= 1'b0;
			out.hsync <= 1'b0;
			out.vsync <= 1'b0;
			out.blank <= 1'b1;
		end else begin
			out.stb <= pix.stb;
			if (pix.stb) begin
				out.rgb   <= ram[pix.index];
				out.hsync <= pix.hsync;
				out.vsync <= pix.vsync;
				out.blank <= pix.blank;
			end
		end
	end

endmodule

//--- verilog/video_top.sv
// video top level joining timing, fetch, render and palette
`timescale 1ns/1ps
`include "video_config.svh"

module video_top
	import video_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  video_mode_t            mode,
	input  logic [7:0]             border,
	input  logic [`VID_ADDR_W-1:0] frame_base,
	input  pal_wr_t                pal_wr,
	output logic                   mem_rd,
	output logic [`VID_ADDR_W-1:0] mem_addr,
	input  logic [31:0]            mem_rdata,
	output video_out_t             video_out
);

	beam_ctrl_t  beam;
	logic        frame_start;
	logic        take;
	logic [31:0] word;
	pix_idx_t    pix;

	video_timing u_timing (
		.clk         (clk),
		.rst_n       (rst_n),
		.mode        (mode),
		.beam        (beam),
		.frame_start (frame_start)
	);

	video_fetch u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.beam        (beam),
		.frame_start (frame_start),
		.frame_base  (frame_base),
		.take        (take),
		.word        (word),
		.mem_rd      (mem_rd),
		.mem_addr    (mem_addr),
		.mem_rdata   (mem_rdata)
	);

	video_render u_render (
		.clk    (clk),
		.rst_n  (rst_n),
		.beam   (beam),
		.mode   (mode),
		.border (border),
		.word   (word),
		.take   (take),
		.pix    (pix)
	);

	video_palette u_palette (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (pal_wr),
		.pix   (pix),
		.out   (video_out)
	);

endmodule

//--- dv/video_assertions.sv
// video protocol assertions on fetch reads, read data capture and output latency
`timescale 1ns/1ps

module video_assertions
	import video_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input beam_ctrl_t  beam,
	input logic        take,
	input logic        mem_rd,
	input logic [31:0] mem_rdata,
	input logic [31:0] word,
	input video_out_t  video_out
);

	int fails = 0;

	// every take is followed by a refill read on the next clock
	take_then_read: assert property (@(posedge clk) disable iff (!rst_n)
		$past(take) |-> mem_rd)
		else begin
			fails++;
			$error("take not followed by a read strobe");
		end

	// memory answers one clock after the strobe, the buffer holds it one clock later
	rdata_to_word: assert property (@(posedge clk) disable iff (!rst_n)
		$past(mem_rd, 2) |-> word == $past(mem_rdata))
		else begin
			fails++;
			$error("read data not consumed one clock after mem_rd");
		end

	// render register plus palette register
	out_latency: assert property (@(posedge clk) disable iff (!rst_n)
		video_out.stb == $past(beam.pix_stb, 2))
		else begin
			fails++;
			$error("video_out.stb does not follow pix_stb by two clocks");
		end

endmodule

bind video_top video_assertions u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.beam      (beam),
	.take      (take),
	.mem_rd    (mem_rd),
	.mem_rdata (mem_rdata),
	.word      (word),
	.video_out (video_out)
);

//--- dv/video_tb.sv
// video testbench driving random frames through the subsystem and checking a raster model
`timescale 1ns/1ps
`include "video_config.svh"

module video_tb
	import video_pkg::*;
();

	localparam int STB_TIMEOUT = 16;
	localparam int FRAME_STBS  = `VID_V_TOTAL * `VID_H_TOTAL;
	localparam int CHECK_STBS  = `VID_V_SYNC_LINE * `VID_H_TOTAL;
	localparam int SKIP_STBS   = (`VID_V_TOTAL - `VID_V_SYNC_LINE - 1) * `VID_H_TOTAL - 1;

	typedef logic [`VID_ADDR_W-1:0] addr_t;

	logic        clk;
	logic        rst_n;
	video_mode_t mode;
	logic [7:0]  border;
	addr_t       frame_base;
	pal_wr_t     pal_wr;
	logic        mem_rd;
	addr_t       mem_addr;
	logic [31:0] mem_rdata = '0;
	video_out_t  video_out;

	logic [31:0] mem [1 << `VID_ADDR_W];
	logic [15:0] pal_shadow [256];
	addr_t       addr_base;
	addr_t       exp_addr;
	int          addr_gen = 0;
	int          seen_gen = 0;
	int          pix_errs = 0;
	int          addr_errs = 0;
	int          other_errs = 0;
	logic        timed_out = 1'b0;

	video_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.border     (border),
		.frame_base (frame_base),
		.pal_wr     (pal_wr),
		.mem_rd     (mem_rd),
		.mem_addr   (mem_addr),
		.mem_rdata  (mem_rdata),
		.video_out  (video_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// screen memory answers one clock after the read strobe
	always @(posedge clk) begin
		if (mem_rd)
			mem_rdata <= mem[mem_addr];
	end

	// a new frame restarts the expected read address at its base
	always @(posedge clk) begin
		if (addr_gen != seen_gen) begin
			seen_gen <= addr_gen;
			exp_addr <= addr_base;
		end else if (mem_rd && seen_gen != 0) begin
			check_addr("fetch address", exp_addr, mem_addr);
			exp_addr <= exp_addr + addr_t'(1);
		end
	end

	task automatic check_pixel(string name, video_out_t exp, video_out_t act);
		if (act !== exp) begin
			pix_errs++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (act !== exp) begin
			addr_errs++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// gap is the number of clocks since the previous output strobe
	task automatic wait_stb(output int gap);
		gap = 0;
		do begin
			@(posedge clk);
			gap++;
		end while (!video_out.stb && gap < STB_TIMEOUT);
		if (!video_out.stb) begin
			other_errs++;
			timed_out = 1'b1;
			$display("ERROR: no pixel strobe within %0d clocks", STB_TIMEOUT);
		end
	endtask

	task automatic wait_vsync(logic level);
		int gap;
		int n;
		n = 0;
		do begin
			wait_stb(gap);
			n++;
		end while (!timed_out && video_out.vsync !== level && n < FRAME_STBS);
		if (!timed_out && video_out.vsync !== level) begin
			other_errs++;
			timed_out = 1'b1;
			$display("ERROR: vsync did not go to %0b within one frame", level);
		end
	endtask

	// expected output for line v and pixel strobe h of the frame
	function automatic video_out_t model_pixel(int v, int h);
		video_out_t  px;
		logic [31:0] w;
		logic [7:0]  attr;
		logic [7:0]  idx;
		int          ppw;
		int          n;
		ppw = (mode.render == RENDER_HC) ? 8 : (mode.render == RENDER_XC) ? 4 : 16;
		n   = h % ppw;
		w   = mem[addr_t'(int'(frame_base) + v * (`VID_H_ACTIVE / ppw) + h / ppw)];
		case (mode.render)
			RENDER_ZX: begin
				attr = (n < 8) ? w[31:24] : w[23:16];
				idx  = {4'hF, attr[6], w[15 - n] ? attr[2:0] : attr[5:3]};
			end
			RENDER_HC: idx = {4'hE, w[(n / 2) * 8 + ((n % 2 == 0) ? 4 : 0) +: 4]};
			RENDER_XC: idx = w[n * 8 +: 8];
			default:   idx = 8'h00;
		endcase
		px.blank = !(v < `VID_V_ACTIVE && h < `VID_H_ACTIVE);
		if (px.blank)
			idx = border;
		px.stb   = 1'b1;
		px.rgb   = pal_shadow[idx];
		px.hsync = h >= `VID_H_SYNC_START && h < `VID_H_SYNC_START + `VID_H_SYNC_LEN;
		px.vsync = v == `VID_V_SYNC_LINE;
		return px;
	endfunction

	task automatic write_palette(logic [7:0] a, logic [15:0] c);
		@(posedge clk);
		pal_wr <= '{we: 1'b1, addr: a, rgb: c};
		pal_shadow[a] = c;
	endtask

	// new settings go in during vsync, then lines 0 up to vsync are checked
	task automatic run_frame(string name, render_mode_e r, logic hires, int n_pal);
		addr_t b;
		int    gap;
		wait_vsync(1'b1);
		if (timed_out)
			return;
		b = addr_t'($urandom);
		@(posedge clk);
		mode       <= '{render: r, hires: hires};
		border     <= 8'($urandom);
		frame_base <= b;
		addr_base  <= b;
		addr_gen   <= addr_gen + 1;
		repeat (n_pal)
			write_palette(8'($urandom), 16'($urandom));
		@(posedge clk);
		pal_wr <= '0;
		wait_vsync(1'b0);
		for (int i = 0; i < SKIP_STBS && !timed_out; i++)
			wait_stb(gap);
		for (int i = 0; i < CHECK_STBS && !timed_out; i++) begin
			wait_stb(gap);
			if (!timed_out) begin
				check_pixel($sformatf("%s pixel %0d", name, i),
					model_pixel(i / `VID_H_TOTAL, i % `VID_H_TOTAL), video_out);
				if (!mode.hires && i > 0 && gap < 2) begin
					other_errs++;
					$display("ERROR: back to back pixel strobes in lores frame %s", name);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'h5170));
		rst_n      = 1'b0;
		mode       = '{render: RENDER_ZX, hires: 1'b0};
		border     = '0;
		frame_base = '0;
		pal_wr     = '0;
		for (int a = 0; a < (1 << `VID_ADDR_W); a++)
			mem[a] = $urandom;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// palette RAM powers up unknown
		for (int a = 0; a < 256; a++)
			write_palette(8'(a), 16'($urandom));
		@(posedge clk);
		pal_wr <= '0;
		run_frame("zx lores", RENDER_ZX, 1'b0, 0);
		run_frame("16c lores", RENDER_HC, 1'b0, 8);
		run_frame("256c lores", RENDER_XC, 1'b0, 8);
		run_frame("test lores", RENDER_TEST, 1'b0, 8);
		run_frame("zx hires", RENDER_ZX, 1'b1, 8);
		run_frame("16c hires", RENDER_HC, 1'b1, 8);
		run_frame("256c hires", RENDER_XC, 1'b1, 8);
		$display("errors: pixel %0d, address %0d, other %0d, assertion %0d",
			pix_errs, addr_errs, other_errs, DUT.u_assert.fails);
		if (pix_errs + addr_errs + other_errs + DUT.u_assert.fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+verilog
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_fetch.sv
verilog/video_render.sv
verilog/video_palette.sv
verilog/video_top.sv
dv/video_assertions.sv
dv/video_tb.sv

//--- Makefile
# Verilator build and run of the video subsystem testbench

VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -Wno-fatal

PASS_MSG  := Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
